// ==== source/loadStore_defs.svh ====
`ifndef LOADSTORE_DEFS_SVH
`define LOADSTORE_DEFS_SVH

// Size of the data memory in 32-bit words
`define LSU_MEM_WORDS 1024

// Request queue depth
// The requester also starts with this many request credits
`define LSU_REQ_DEPTH 4

// Response credits held by the unit right after reset
`define LSU_RSP_CREDITS 2

`endif

// ==== source/lsuDataPkg.sv ====
`default_nettype none
`include "loadStore_defs.svh"

// Plain vector types for the data path
package lsuDataPkg;

    // One memory word or register value
    typedef logic [31:0] dataWord;

    // Byte address as it comes from the pipeline
    typedef logic [31:0] byteAddress;

    // Word select into the memory bank
    // Taken from the address bits just above the lane bits
    typedef logic [$clog2(`LSU_MEM_WORDS)-1:0] wordIndex;

    // Byte position inside a word, lane 0 holds bits 7:0
    typedef logic [1:0] laneOffset;

    // Write mask with one bit per byte lane
    typedef logic [3:0] byteEnable;

endpackage

`default_nettype wire

// ==== source/lsuProtocolPkg.sv ====
`default_nettype none

// Request, internal access and response formats of the unit
package lsuProtocolPkg;
    import lsuDataPkg::*;

    // Memory operations, stores first
    typedef enum logic [2:0] {
        opStoreWord  = 3'd0,    // sw
        opStoreHalf  = 3'd1,    // sh
        opStoreByte  = 3'd2,    // sb
        opLoadWord   = 3'd3,    // lw
        opLoadHalf   = 3'd4,    // lh, sign extended
        opLoadHalfU  = 3'd5,    // lhu
        opLoadByte   = 3'd6,    // lb, sign extended
        opLoadByteU  = 3'd7     // lbu
    } accessOp;

    // What the pipeline hands in
    typedef struct packed {
        accessOp    op;
        byteAddress address;
        dataWord    writeData;      // Low bits hold the half or byte for narrow stores
    } lsuRequest;

    // Decoded access travelling from decode to execute and on to result
    typedef struct packed {
        accessOp   op;
        wordIndex  index;
        laneOffset lane;
        byteEnable enables;         // Zero for loads
        dataWord   writeData;       // Already moved onto its lane
        logic      misaligned;
    } issuedAccess;

    // What goes back to the pipeline
    typedef struct packed {
        dataWord loadData;          // Extended load value, zero otherwise
        logic    error;             // Misaligned access
        logic    isLoad;
    } lsuResponse;

endpackage

`default_nettype wire

// ==== source/accessDecode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "loadStore_defs.svh"

module accessDecode (
    input  logic                        Clock,
    input  logic                        reset,
    input  lsuProtocolPkg::lsuRequest   request,
    input  logic                        reqValid,
    output logic                        reqCredit,
    input  logic                        rspCredit,
    output lsuProtocolPkg::issuedAccess access,
    output logic                        accessValid
);
    import lsuDataPkg::*;
    import lsuProtocolPkg::*;

    localparam int PtrBits    = $clog2(`LSU_REQ_DEPTH);
    localparam int FillBits   = $clog2(`LSU_REQ_DEPTH + 1);
    localparam int CreditBits = $clog2(`LSU_RSP_CREDITS + 1);
    localparam int IndexBits  = $bits(wordIndex);

    lsuRequest             queue [`LSU_REQ_DEPTH];    // Circular request store
    logic [PtrBits-1:0]    writePtr;
    logic [PtrBits-1:0]    readPtr;
    logic [FillBits-1:0]   fill;                      // Entries waiting
    logic [CreditBits-1:0] credits;                   // Response slots the consumer granted
    logic                  pop;
    lsuRequest             head;
    laneOffset             lane;
    byteEnable             enables;
    logic                  misaligned;
    logic                  isStore;

    // Issue only when something waits and its response has somewhere to go
    assign pop  = (fill != '0) && (credits != '0);
    assign head = queue[readPtr];
    assign lane = head.address[1:0];

    assign isStore = head.op inside {opStoreWord, opStoreHalf, opStoreByte};

    always_comb begin
        case (head.op)
            opStoreWord, opLoadWord: begin
                enables    = 4'b1111;
                misaligned = (lane != 2'd0);    // Words only on lane 0
            end
            opStoreHalf, opLoadHalf, opLoadHalfU: begin
                enables    = byteEnable'(4'b0011 << lane);
                misaligned = lane[0];           // Halves on lanes 0 and 2
            end
            default: begin                      // Byte access, any lane is fine
                enables    = byteEnable'(4'b0001 << lane);
                misaligned = 1'b0;
            end
        endcase
        if (!isStore) begin
            enables = '0;   // Loads never write
        end
    end

    // Queue storage
    always_ff @(posedge Clock) begin
        if (reqValid) begin
            queue[writePtr] <= request;
        end
    end

    // Pointers, fill level and credits
    always_ff @(posedge Clock) begin
        if (reset) begin
            writePtr    <= '0;
            readPtr     <= '0;
            fill        <= '0;
            credits     <= CreditBits'(`LSU_RSP_CREDITS);
            reqCredit   <= 1'b0;
            accessValid <= 1'b0;
        end else begin
            if (reqValid) begin
                writePtr <= (writePtr == PtrBits'(`LSU_REQ_DEPTH - 1)) ? '0 : writePtr + 1'b1;
            end
            if (pop) begin
                readPtr <= (readPtr == PtrBits'(`LSU_REQ_DEPTH - 1)) ? '0 : readPtr + 1'b1;
            end
            fill        <= fill + FillBits'(reqValid) - FillBits'(pop);
            credits     <= credits - CreditBits'(pop) + CreditBits'(rspCredit);
            reqCredit   <= pop;     // Freed slot goes back to the requester
            accessValid <= pop;
        end
    end

    // Decoded access register
    always_ff @(posedge Clock) begin
        if (pop) begin
            access.op         <= head.op;
            access.index      <= head.address[IndexBits+1:2];
            access.lane       <= lane;
            access.enables    <= enables;
            access.writeData  <= dataWord'(head.writeData << {lane, 3'b000});
            access.misaligned <= misaligned;
        end
    end

    // Requester must hold a credit for every send
    assert property (@(posedge Clock) disable iff (reset)
        reqValid |-> (fill != FillBits'(`LSU_REQ_DEPTH)));

    // Consumer never hands back more credits than it was given
    assert property (@(posedge Clock) disable iff (reset)
        credits <= CreditBits'(`LSU_RSP_CREDITS));

endmodule

`default_nettype wire

// ==== source/dataMemoryBank.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "loadStore_defs.svh"

module dataMemoryBank (
    input  logic                        Clock,
    input  logic                        reset,
    input  lsuProtocolPkg::issuedAccess access,
    input  logic                        accessValid,
    output lsuDataPkg::dataWord         readWord,
    output lsuProtocolPkg::issuedAccess accessOut,
    output logic                        accessOutValid
);
    import lsuDataPkg::*;
    import lsuProtocolPkg::*;

    dataWord memory [`LSU_MEM_WORDS];   // Word organized, lane 0 in bits 7:0
    logic    writeEnable;

    // Misaligned stores must leave memory untouched
    assign writeEnable = accessValid && !access.misaligned;

    // Byte lane writes
    // Load enables are all zero so loads fall through here
    always_ff @(posedge Clock) begin
        for (int b = 0; b < 4; b++) begin
            if (writeEnable && access.enables[b]) begin
                memory[access.index][8*b +: 8] <= access.writeData[8*b +: 8];
            end
        end
    end

    // Whole word read, registered together with the access
    always_ff @(posedge Clock) begin
        if (accessValid) begin
            readWord  <= memory[access.index];  // Old value if a store hits this word now
            accessOut <= access;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            accessOutValid <= 1'b0;
        end else begin
            accessOutValid <= accessValid;
        end
    end

    // Decode must hand over a known word index and write mask with every valid access
    assert property (@(posedge Clock) disable iff (reset)
        accessValid |-> !$isunknown({access.index, access.enables, access.misaligned}));

endmodule

`default_nettype wire

// ==== source/loadAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadAlign (
    input  logic                        Clock,
    input  logic                        reset,
    input  lsuDataPkg::dataWord         readWord,
    input  lsuProtocolPkg::issuedAccess accessOut,
    input  logic                        accessOutValid,
    output lsuProtocolPkg::lsuResponse  response,
    output logic                        rspValid
);
    import lsuDataPkg::*;
    import lsuProtocolPkg::*;

    logic [7:0]  laneByte;      // Byte at the access lane
    logic [15:0] laneHalf;      // Half at lane 0 or 2
    dataWord     loadData;
    logic        isLoad;

    assign laneByte = readWord[{accessOut.lane, 3'b000} +: 8];
    assign laneHalf = readWord[{accessOut.lane[1], 4'b0000} +: 16];

    assign isLoad = !(accessOut.op inside {opStoreWord, opStoreHalf, opStoreByte});

    always_comb begin
        case (accessOut.op)
            opLoadWord:  loadData = readWord;
            opLoadHalf:  loadData = {{16{laneHalf[15]}}, laneHalf};
            opLoadHalfU: loadData = {16'b0, laneHalf};
            opLoadByte:  loadData = {{24{laneByte[7]}}, laneByte};
            opLoadByteU: loadData = {24'b0, laneByte};
            default:     loadData = '0;     // Stores carry no data back
        endcase
        if (accessOut.misaligned) begin
            loadData = '0;
        end
    end

    // Response register
    always_ff @(posedge Clock) begin
        if (accessOutValid) begin
            response.loadData <= loadData;
            response.error    <= accessOut.misaligned;
            response.isLoad   <= isLoad;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            rspValid <= 1'b0;
        end else begin
            rspValid <= accessOutValid;     // One response per access
        end
    end

endmodule

`default_nettype wire

// ==== source/loadStoreUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
    input  logic                       Clock,
    input  logic                       reset,
    input  lsuProtocolPkg::lsuRequest  request,
    input  logic                       reqValid,
    output logic                       reqCredit,
    output lsuProtocolPkg::lsuResponse response,
    output logic                       rspValid,
    input  logic                       rspCredit
);
    import lsuDataPkg::*;
    import lsuProtocolPkg::*;

    issuedAccess decodedAccess;     // Decode to execute
    logic        decodedValid;
    dataWord     readWord;          // Execute to result
    issuedAccess bankAccess;
    logic        bankValid;

    accessDecode decodeStage (
        .Clock       (Clock),
        .reset       (reset),
        .request     (request),
        .reqValid    (reqValid),
        .reqCredit   (reqCredit),
        .rspCredit   (rspCredit),
        .access      (decodedAccess),
        .accessValid (decodedValid)
    );

    dataMemoryBank executeStage (
        .Clock          (Clock),
        .reset          (reset),
        .access         (decodedAccess),
        .accessValid    (decodedValid),
        .readWord       (readWord),
        .accessOut      (bankAccess),
        .accessOutValid (bankValid)
    );

    loadAlign resultStage (
        .Clock          (Clock),
        .reset          (reset),
        .readWord       (readWord),
        .accessOut      (bankAccess),
        .accessOutValid (bankValid),
        .response       (response),
        .rspValid       (rspValid)
    );

endmodule

`default_nettype wire

// ==== bench/loadStoreUnitBench.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "loadStore_defs.svh"

module loadStoreUnitBench;
    import lsuDataPkg::*;
    import lsuProtocolPkg::*;

    localparam int TotalRequests = 245;     // Sum over all six tests
    localparam int RefBytes      = 4 * `LSU_MEM_WORDS;

    logic       Clock;
    logic       reset;
    lsuRequest  request;
    logic       reqValid;
    logic       reqCredit;
    lsuResponse response;
    logic       rspValid;
    logic       rspCredit;

    logic [7:0] refMemory [RefBytes];       // Byte addressed, little endian
    lsuResponse expected [$];               // Responses still owed, oldest first
    int requestCredits  = `LSU_REQ_DEPTH;
    int reqCreditCount  = 0;
    int received        = 0;
    int creditsToReturn = 0;
    int heldBack        = 0;                // Credits kept back from the unit
    bit withhold        = 0;
    bit sendsDone       = 0;
    int errors          = 0;
    int testStartErrors = 0;
    int testsPassed     = 0;
    int testsFailed     = 0;

    loadStoreUnit DUT (
        .Clock     (Clock),
        .reset     (reset),
        .request   (request),
        .reqValid  (reqValid),
        .reqCredit (reqCredit),
        .response  (response),
        .rspValid  (rspValid),
        .rspCredit (rspCredit)
    );

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    // Expected response from the lane, extension and alignment rules
    function automatic lsuResponse modelAccess(accessOp op, byteAddress address, dataWord data);
        lsuResponse rsp;
        int         a;
        logic [15:0] half;
        a    = int'(address);
        rsp  = '0;
        half = {refMemory[a+1], refMemory[a]};
        rsp.isLoad = !(op inside {opStoreWord, opStoreHalf, opStoreByte});
        case (op)
            opStoreWord, opLoadWord:              rsp.error = (address[1:0] != 2'd0);
            opStoreHalf, opLoadHalf, opLoadHalfU: rsp.error = address[0];
            default:                              rsp.error = 1'b0;
        endcase
        if (!rsp.error) begin       // Misaligned leaves memory alone and returns zero
            case (op)
                opStoreWord: for (int i = 0; i < 4; i++) refMemory[a+i] = data[8*i +: 8];
                opStoreHalf: {refMemory[a+1], refMemory[a]} = data[15:0];
                opStoreByte: refMemory[a] = data[7:0];
                opLoadWord:  rsp.loadData = {refMemory[a+3], refMemory[a+2], half};
                opLoadHalf:  rsp.loadData = {{16{half[15]}}, half};
                opLoadHalfU: rsp.loadData = {16'h0000, half};
                opLoadByte:  rsp.loadData = {{24{refMemory[a][7]}}, refMemory[a]};
                default:     rsp.loadData = {24'h000000, refMemory[a]};
            endcase
        end
        return rsp;
    endfunction

    task automatic compareData(input dataWord got, input dataWord want, input string what);
        if (got !== want) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic compareFlag(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, want);
            errors++;
        end
    endtask

    // Requester and response collector, sampled mid cycle
    always @(negedge Clock) begin
        lsuResponse want;
        if (!reset) begin
            if (reqCredit === 1'b1) begin
                requestCredits++;
                reqCreditCount++;
            end
            if (rspValid === 1'b1) begin
                received++;
                if (expected.size() == 0) begin
                    $display("Response at %0t ns arrived with no request outstanding", $time);
                    errors++;
                end else begin
                    want = expected.pop_front();
                    compareData(response.loadData, want.loadData, "load data");
                    compareFlag(response.error, want.error, "error flag");
                    compareFlag(response.isLoad, want.isLoad, "isLoad flag");
                end
                if (withhold) heldBack++;
                else creditsToReturn++;
            end
        end
    end

    // One returned credit per cycle at most
    always @(posedge Clock) begin
        #2;
        if (creditsToReturn > 0) begin
            rspCredit = 1'b1;
            creditsToReturn--;
        end else begin
            rspCredit = 1'b0;
        end
    end

    initial begin
        repeat (40 * TotalRequests + 200) @(posedge Clock);
        $display("Watchdog: run did not finish, %0d responses still missing", expected.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

    // Spends a request credit, stalls while none is left
    task automatic sendRequest(input accessOp op, input byteAddress address, input dataWord data);
        @(posedge Clock);
        #2;
        while (requestCredits == 0) begin
            reqValid = 1'b0;
            @(posedge Clock);
            #2;
        end
        request.op        = op;
        request.address   = address;
        request.writeData = data;
        reqValid          = 1'b1;
        requestCredits--;
        expected.push_back(modelAccess(op, address, data));
    endtask

    task automatic endRequests();
        @(posedge Clock);
        #2;
        reqValid = 1'b0;
    endtask

    // Waits out all responses and credits, then reports the test
    task automatic completeTest(input string name);
        endRequests();
        while (expected.size() != 0 || creditsToReturn != 0) @(negedge Clock);
        repeat (2) @(posedge Clock);
        if (errors == testStartErrors) begin
            testsPassed++;
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, errors - testStartErrors);
        end
        testStartErrors = errors;
    endtask

    task automatic creditTest();
        int rspStart;
        int creditStart;
        rspStart    = received;
        creditStart = reqCreditCount;
        withhold    = 1'b1;
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    sendRequest(opStoreWord, 32'h140 + 4*i, 32'hC0DE0000 + i);
                end
                for (int i = 0; i < 4; i++) begin
                    sendRequest(opLoadWord, 32'h140 + 4*i, '0);
                end
                endRequests();
                sendsDone = 1'b1;
            end
        join_none
        repeat (30) @(posedge Clock);   // Long enough for the queue to block
        if (received - rspStart != `LSU_RSP_CREDITS) begin
            $display("Credit test: %0d responses came without credits, expected %0d",
                     received - rspStart, `LSU_RSP_CREDITS);
            errors++;
        end
        if (reqCreditCount - creditStart != `LSU_RSP_CREDITS) begin
            $display("Credit test: reqCredit pulsed %0d times while blocked, expected %0d",
                     reqCreditCount - creditStart, `LSU_RSP_CREDITS);
            errors++;
        end
        withhold        = 1'b0;
        creditsToReturn = creditsToReturn + heldBack;
        heldBack        = 0;
        wait (sendsDone);
        while (expected.size() != 0) @(negedge Clock);  // Every pop is counted by now
        if (reqCreditCount - creditStart != 8) begin
            $display("Credit test: %0d reqCredit pulses for 8 requests",
                     reqCreditCount - creditStart);
            errors++;
        end
        completeTest("response back-pressure");
    endtask

    task automatic randomTest();
        accessOp op;
        for (int w = 0; w < 16; w++) sendRequest(opStoreWord, 32'h200 + 4*w, $urandom);
        for (int n = 0; n < 200; n++) begin
            op = accessOp'(3'($urandom_range(7, 0)));
            sendRequest(op, 32'h200 + $urandom_range(63, 0), $urandom);
        end
        completeTest("random operations");
    endtask

    initial begin
        void'($urandom(17));
        request   = '0;
        reqValid  = 1'b0;
        rspCredit = 1'b0;
        reset     = 1'b1;
        repeat (5) @(posedge Clock);
        #2;
        reset = 1'b0;
        sendRequest(opStoreWord, 32'h40, 32'hDEADBEEF);
        sendRequest(opLoadWord, 32'h40, '0);
        completeTest("word store and load");
        sendRequest(opStoreByte, 32'h80, 32'h11);
        sendRequest(opStoreByte, 32'h81, 32'h22);
        sendRequest(opStoreByte, 32'h82, 32'h93);   // Negative byte
        sendRequest(opStoreByte, 32'h83, 32'h44);
        sendRequest(opLoadWord, 32'h80, '0);
        sendRequest(opLoadByte, 32'h82, '0);
        sendRequest(opLoadByteU, 32'h82, '0);
        completeTest("byte lanes");
        sendRequest(opStoreHalf, 32'hC0, 32'h8001);
        sendRequest(opStoreHalf, 32'hC2, 32'h7FFE);
        sendRequest(opLoadHalf, 32'hC0, '0);
        sendRequest(opLoadHalfU, 32'hC0, '0);
        sendRequest(opLoadHalf, 32'hC2, '0);
        sendRequest(opLoadHalfU, 32'hC2, '0);
        completeTest("halfword lanes");
        sendRequest(opStoreWord, 32'h100, 32'h12345678);
        sendRequest(opStoreHalf, 32'h101, 32'hAAAA);    // Odd lane
        sendRequest(opStoreWord, 32'h102, 32'hBBBBBBBB);
        sendRequest(opLoadHalf, 32'h103, '0);
        sendRequest(opLoadWord, 32'h101, '0);
        sendRequest(opLoadWord, 32'h100, '0);           // Must still be the first store
        completeTest("misaligned accesses");
        creditTest();
        randomTest();
        $display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/lsuDataPkg.sv
source/lsuProtocolPkg.sv
source/accessDecode.sv
source/dataMemoryBank.sv
source/loadAlign.sv
source/loadStoreUnit.sv
bench/loadStoreUnitBench.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= loadStoreUnitBench
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
